// File: compile.f
logic/walkie_pkg.sv
logic/bit_clock_gen.sv
logic/i2s_receiver.sv
logic/audio_effect.sv
logic/i2s_transmitter.sv
logic/walkie_audio_top.sv
testbench/audio_properties.sv
testbench/audio_checker.sv
testbench/audio_tb.sv

// File: logic/audio_effect.sv
`timescale 1ns/1ps
`default_nettype none

module audio_effect
  import walkie_pkg::*;
(
  input  logic    hwclk,
  input  logic    rst,
  input  sample_t sample,
  input  logic    sample_valid,
  input  effect_e effect_sel,
  input  volume_t volume,
  output sample_t effect_sample,
  output logic    effect_valid
);

  sample_t attenuated; // Arithmetic shift by volume
  sample_t inverted;   // Negated with saturation
  sample_t crushed;    // Low bits cleared
  sample_t fx_result;  // Selected effect

  assign attenuated = sample >>> volume;  // Sign kept
  assign crushed    = {sample[WORD_BITS-1:CRUSH_BITS], {CRUSH_BITS{1'b0}}};

  // -128 has no positive twin
  always_comb begin
    if (sample == SAMPLE_MIN) begin
      inverted = SAMPLE_MAX;
    end else begin
      inverted = -sample;
    end
  end

  always_comb begin
    case (effect_sel)
      MUTE:      fx_result = '0;
      ATTENUATE: fx_result = attenuated;
      INVERT:    fx_result = inverted;
      CRUSH:     fx_result = crushed;
      default:   fx_result = sample;  // BYPASS and unused codes
    endcase
  end

  // Valid follows by one cycle
  always_ff @(posedge hwclk) begin
    if (rst) begin
      effect_valid <= 1'b0;
    end else begin
      effect_valid <= sample_valid;
    end
  end

  // Pins sampled together with the sample
  always_ff @(posedge hwclk) begin
    if (sample_valid) begin
      effect_sample <= fx_result;
    end
  end

endmodule

`default_nettype wire

// File: logic/bit_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module bit_clock_gen
  import walkie_pkg::*;
(
  input  logic hwclk,
  input  logic rst,
  output logic i2sclk,
  output logic ws,
  output logic bit_rise,
  output logic bit_fall,
  output logic word_start
);

  logic [DIV_W-1:0] div_cnt;  // hwclk count within half period
  bit_idx_t         bit_cnt;  // Bit index, advances on falls
  logic             div_done; // Half period elapsed
  logic             last_bit; // Bit 7 of current word

  assign div_done = (div_cnt == DIV_W'(BIT_DIV - 1));
  assign last_bit = (bit_cnt == BIT_W'(WORD_BITS - 1));

  always_ff @(posedge hwclk) begin
    if (rst) begin
      div_cnt    <= '0;
      bit_cnt    <= '0;
      i2sclk     <= 1'b0;
      ws         <= 1'b0;  // Frame opens on left word
      bit_rise   <= 1'b0;
      bit_fall   <= 1'b0;
      word_start <= 1'b0;
    end else begin
      bit_rise   <= 1'b0;  // Strobes last one cycle
      bit_fall   <= 1'b0;
      word_start <= 1'b0;

      if (div_done) begin
        div_cnt <= '0;
        i2sclk  <= ~i2sclk;
        if (!i2sclk) begin
          bit_rise <= 1'b1;  // Low to high
        end else begin
          bit_fall <= 1'b1;  // High to low, ends a bit
          if (last_bit) begin
            bit_cnt    <= '0;
            ws         <= ~ws;  // Next word, other channel
            word_start <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/i2s_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_receiver
  import walkie_pkg::*;
(
  input  logic    hwclk,
  input  logic    rst,
  input  logic    adc_serial_in,
  input  logic    ws,
  input  logic    bit_rise,
  output sample_t sample,
  output logic    sample_valid
);

  sample_t  shift_reg; // Partial word, MSB first
  bit_idx_t bit_cnt;   // Bits taken in this word
  logic     word_full; // Current rise takes bit 7
  sample_t  next_word; // Shift register after this bit

  assign word_full = (bit_cnt == BIT_W'(WORD_BITS - 1));
  assign next_word = {shift_reg[WORD_BITS-2:0], adc_serial_in};

  // Bit counting and valid pulse
  always_ff @(posedge hwclk) begin
    if (rst) begin
      bit_cnt      <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= 1'b0;
      if (bit_rise) begin
        if (word_full) begin
          bit_cnt      <= '0;
          sample_valid <= ~ws;  // Left word only
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // Data path
  always_ff @(posedge hwclk) begin
    if (bit_rise) begin
      shift_reg <= next_word;
      if (word_full && !ws) begin
        sample <= next_word;  // Held until next left word
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/i2s_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_transmitter
  import walkie_pkg::*;
(
  input  logic    hwclk,
  input  logic    rst,
  input  sample_t effect_sample,
  input  logic    effect_valid,
  input  logic    ws,
  input  logic    bit_fall,
  input  logic    word_start,
  output logic    dac_out
);

  tx_state_e state;      // IDLE until frame seen
  sample_t   hold_reg;   // Latest effected sample
  sample_t   shift_reg;  // Bits still to send
  sample_t   load_word;  // Word loaded at boundary

  // ws already shows the new channel at word_start
  assign load_word = ws ? sample_t'(0) : hold_reg;  // Right word is silent

  // Holding register
  always_ff @(posedge hwclk) begin
    if (effect_valid) begin
      hold_reg <= effect_sample;
    end
  end

  always_ff @(posedge hwclk) begin
    if (rst) begin
      state     <= IDLE;
      shift_reg <= '0;
      dac_out   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (word_start) begin
            state     <= SHIFT;
            dac_out   <= load_word[WORD_BITS-1];  // MSB on this fall
            shift_reg <= {load_word[WORD_BITS-2:0], 1'b0};
          end
        end
        SHIFT: begin
          if (word_start) begin
            dac_out   <= load_word[WORD_BITS-1];
            shift_reg <= {load_word[WORD_BITS-2:0], 1'b0};
          end else if (bit_fall) begin
            dac_out   <= shift_reg[WORD_BITS-1];  // Next bit out
            shift_reg <= {shift_reg[WORD_BITS-2:0], 1'b0};
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/walkie_audio_top.sv
`timescale 1ns/1ps
`default_nettype none

module walkie_audio_top
  import walkie_pkg::*;
(
  input  logic    hwclk,
  input  logic    rst,
  input  logic    adc_serial_in,
  input  effect_e effect_sel,
  input  volume_t volume,
  output logic    i2sclk,
  output logic    ws,
  output logic    dac_out
);

  logic    bit_rise;      // Shared frame strobes
  logic    bit_fall;
  logic    word_start;
  sample_t sample;        // Receiver to effect stage
  logic    sample_valid;
  sample_t effect_sample; // Effect stage to transmitter
  logic    effect_valid;

  bit_clock_gen i_clk (
    .hwclk(hwclk), .rst(rst),
    .i2sclk(i2sclk), .ws(ws),  // Shared by ADC and DAC
    .bit_rise(bit_rise), .bit_fall(bit_fall), .word_start(word_start)
  );

  i2s_receiver i_rx (
    .hwclk(hwclk), .rst(rst),
    .adc_serial_in(adc_serial_in),             // From ADC pin
    .ws(ws), .bit_rise(bit_rise),              // From clock gen
    .sample(sample), .sample_valid(sample_valid)
  );

  audio_effect i_fx (
    .hwclk(hwclk), .rst(rst),
    .sample(sample), .sample_valid(sample_valid),
    .effect_sel(effect_sel), .volume(volume),  // Button stand-ins
    .effect_sample(effect_sample), .effect_valid(effect_valid)
  );

  i2s_transmitter i_tx (
    .hwclk(hwclk), .rst(rst),
    .effect_sample(effect_sample), .effect_valid(effect_valid),
    .ws(ws), .bit_fall(bit_fall), .word_start(word_start),
    .dac_out(dac_out)                          // To DAC pin
  );

endmodule

`default_nettype wire

// File: logic/walkie_pkg.sv
`default_nettype none

package walkie_pkg;

  // Frame timing
  localparam int BIT_DIV    = 4;  // hwclk cycles per i2sclk half period
  localparam int WORD_BITS  = 8;  // Bits per I2S word
  localparam int CRUSH_BITS = 4;  // Low bits dropped by CRUSH

  // Counter widths derived from timing
  localparam int DIV_W = $clog2(BIT_DIV);    // Divide counter width
  localparam int BIT_W = $clog2(WORD_BITS);  // Bit index width

  // Saturation limits for INVERT
  localparam logic signed [WORD_BITS-1:0] SAMPLE_MIN = {1'b1, {(WORD_BITS-1){1'b0}}};
  localparam logic signed [WORD_BITS-1:0] SAMPLE_MAX = {1'b0, {(WORD_BITS-1){1'b1}}};

  typedef logic signed [WORD_BITS-1:0] sample_t;  // Two's complement audio
  typedef logic [1:0]                  volume_t;  // Right-shift steps
  typedef logic [BIT_W-1:0]            bit_idx_t; // Bit position in word

  typedef enum logic [2:0] {
    BYPASS    = 3'd0,
    MUTE      = 3'd1,
    ATTENUATE = 3'd2,
    INVERT    = 3'd3,
    CRUSH     = 3'd4
  } effect_e;

  typedef enum logic {
    IDLE  = 1'b0,  // Waiting for first word boundary
    SHIFT = 1'b1   // Framed, shifting every bit_fall
  } tx_state_e;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module audio_tb -Mdir obj_dir -o audio_sim \
  -f compile.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/audio_sim > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -qx "ALL TESTS PASSED" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }

// File: testbench/audio_checker.sv
`timescale 1ns/1ps
`default_nettype none

module audio_checker
  import walkie_pkg::*;
(
  input  logic    hwclk,
  input  logic    rst,
  input  logic    i2sclk,
  input  logic    ws,
  input  logic    adc_serial_in,
  input  logic    dac_out,
  input  effect_e effect_sel,
  input  volume_t volume,
  output int      pass_count,
  output int      fail_count,
  output int      left_checked
);

  localparam int WS_PERIOD = 2 * WORD_BITS * 2 * BIT_DIV;  // hwclk cycles per frame

  sample_t model_q[$];      // Expected DAC left words, oldest first
  sample_t adc_word;        // ADC bits of the current word
  sample_t dac_word;        // DAC bits of the current word
  logic    word_ws;         // Channel seen at bit 0
  int      bit_cnt    = 0;
  int      word_pass  = 0;
  int      word_fail  = 0;
  int      frame_pass = 0;
  int      frame_fail = 0;
  int      reset_pass = 0;
  int      reset_fail = 0;
  int      left_done  = 0;  // DAC left words checked
  int      right_done = 0;
  int      hw_cycles  = 0;
  int      last_rise  = -1; // Cycle of previous ws rise

  assign pass_count   = word_pass + frame_pass + reset_pass;
  assign fail_count   = word_fail + frame_fail + reset_fail;
  assign left_checked = left_done;

  function automatic sample_t model_effect(sample_t s, effect_e fx, volume_t vol);
    int v;
    int step;
    v    = int'(s);
    step = 1 << vol;
    case (fx)
      MUTE:      v = 0;
      ATTENUATE: v = (v < 0) ? -((step - 1 - v) / step) : v / step;  // Floor of v/2^vol
      INVERT:    v = (-v > 127) ? 127 : -v;  // Only -128 saturates
      CRUSH:     v = v & ~((1 << CRUSH_BITS) - 1);
      default:   ;  // BYPASS and unused codes
    endcase
    return sample_t'(v);
  endfunction

  task automatic compare_word(input string chan, input int idx, input sample_t expected);
    if (dac_word !== expected) begin
      $display("FAILED dac_out %s word %0d: expected %h, got %h", chan, idx, expected, dac_word);
      word_fail++;
    end else begin
      $display("dac_out %s word %0d: %h ok", chan, idx, dac_word);
      word_pass++;
    end
  endtask

  initial begin
    @(negedge rst);
    if (i2sclk !== 1'b0 || ws !== 1'b0 || dac_out !== 1'b0) begin
      $display("FAILED reset state i2sclk/ws/dac_out: expected 0/0/0, got %h/%h/%h",
               i2sclk, ws, dac_out);
      reset_fail++;
    end else begin
      reset_pass++;
    end
  end

  always @(posedge hwclk) begin
    hw_cycles++;
  end

  // One ws rise per frame
  always @(posedge ws) begin
    if (!rst && last_rise >= 0) begin
      if (hw_cycles - last_rise != WS_PERIOD) begin
        $display("FAILED ws period: expected %h, got %h", WS_PERIOD, hw_cycles - last_rise);
        frame_fail++;
      end else begin
        frame_pass++;
      end
    end
    last_rise = hw_cycles;
  end

  // Both lines are stable at the i2sclk rise
  always @(posedge i2sclk) begin
    if (!rst) begin
      if (bit_cnt == 0) begin
        word_ws = ws;
      end else if (ws != word_ws) begin
        $display("ws changed in the middle of a word after %0d bits", bit_cnt);
        word_fail++;
      end
      adc_word = {adc_word[WORD_BITS-2:0], adc_serial_in};
      dac_word = {dac_word[WORD_BITS-2:0], dac_out};
      bit_cnt++;
      if (bit_cnt == WORD_BITS) begin
        bit_cnt = 0;
        if (word_ws) begin
          compare_word("right", right_done, '0);  // Right channel always silent
          right_done++;
        end else begin
          if (left_done == 0) begin
            compare_word("left", 0, '0);  // Nothing loaded before first boundary
          end else begin
            compare_word("left", left_done, model_q.pop_front());
          end
          model_q.push_back(model_effect(adc_word, effect_sel, volume));  // Due next word
          left_done++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/audio_properties.sv
`timescale 1ns/1ps
`default_nettype none

module audio_properties (
  input logic hwclk,
  input logic rst,
  input logic ws,
  input logic dac_out,
  input logic bit_rise,
  input logic bit_fall,
  input logic sample_valid
);

  int assert_fails = 0;  // Failed property count

  // Rise and fall come from opposite i2sclk levels
  strobes_apart: assert property (@(posedge hwclk) disable iff (rst)
    !(bit_rise && bit_fall))
    else begin
      $error("bit_rise and bit_fall high in the same cycle");
      assert_fails++;
    end

  ws_on_fall: assert property (@(posedge hwclk) disable iff (rst)
    $changed(ws) |-> bit_fall)  // Same update raises bit_fall
    else begin
      $error("ws changed outside a bit_fall cycle");
      assert_fails++;
    end

  // Transmitter acts on the strobe one hwclk later
  dac_on_fall: assert property (@(posedge hwclk) disable iff (rst)
    $changed(dac_out) |-> $past(bit_fall))
    else begin
      $error("dac_out changed outside a bit_fall cycle");
      assert_fails++;
    end

  valid_single: assert property (@(posedge hwclk) disable iff (rst)
    sample_valid |=> !sample_valid)
    else begin
      $error("sample_valid high for two cycles in a row");
      assert_fails++;
    end

endmodule

`default_nettype wire

// File: testbench/audio_tb.sv
`timescale 1ns/1ps
`default_nettype none

module audio_tb
  import walkie_pkg::*;
();

  localparam int ROWS           = 16;
  localparam int CLK_HALF       = 50;  // 100 ns hwclk
  localparam int WORD_CYCLES    = WORD_BITS * 2 * BIT_DIV;
  localparam int TIMEOUT_CYCLES = (ROWS + 4) * 2 * WORD_CYCLES;
  localparam int SEED           = 49034;

  logic    hwclk = 1'b0;
  logic    rst;
  logic    adc_serial_in;
  effect_e effect_sel;
  volume_t volume;
  logic    i2sclk;
  logic    ws;
  logic    dac_out;
  int      pass_count;
  int      fail_count;
  int      left_checked;
  int      cycle_cnt = 0;
  int      seed_val;
  sample_t row_sample [ROWS];  // Stimulus table
  effect_e row_effect [ROWS];
  volume_t row_volume [ROWS];

  walkie_audio_top i_dut (
    .hwclk(hwclk), .rst(rst), .adc_serial_in(adc_serial_in),
    .effect_sel(effect_sel), .volume(volume),
    .i2sclk(i2sclk), .ws(ws), .dac_out(dac_out)
  );

  audio_checker i_chk (
    .hwclk(hwclk), .rst(rst), .i2sclk(i2sclk), .ws(ws),
    .adc_serial_in(adc_serial_in), .dac_out(dac_out),
    .effect_sel(effect_sel), .volume(volume),
    .pass_count(pass_count), .fail_count(fail_count), .left_checked(left_checked)
  );

  bind walkie_audio_top audio_properties i_props (
    .hwclk(hwclk), .rst(rst), .ws(ws), .dac_out(dac_out),
    .bit_rise(bit_rise), .bit_fall(bit_fall), .sample_valid(sample_valid)
  );

  always #CLK_HALF hwclk = ~hwclk;

  always @(posedge hwclk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d hwclk cycles with DAC words still missing", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic set_row(input int idx, input sample_t s, input effect_e fx, input volume_t vol);
    row_sample[idx] = s;
    row_effect[idx] = fx;
    row_volume[idx] = vol;
  endtask

  task automatic fill_table();
    set_row(0,  8'h35,      BYPASS,    2'd0);
    set_row(1,  SAMPLE_MIN, BYPASS,    2'd3);  // Volume ignored here
    set_row(2,  SAMPLE_MAX, CRUSH,     2'd1);
    set_row(3,  8'hff,      CRUSH,     2'd2);
    set_row(4,  8'h6c,      ATTENUATE, 2'd0);
    set_row(5,  8'h9c,      ATTENUATE, 2'd1);  // -100
    set_row(6,  SAMPLE_MAX, ATTENUATE, 2'd2);
    set_row(7,  SAMPLE_MIN, ATTENUATE, 2'd3);
    set_row(8,  SAMPLE_MIN, INVERT,    2'd0);  // Saturates
    set_row(9,  SAMPLE_MAX, INVERT,    2'd0);
    set_row(10, 8'hff,      INVERT,    2'd1);
    set_row(11, 8'h00,      INVERT,    2'd2);
    set_row(12, 8'h5a,      MUTE,      2'd3);
    for (int i = 13; i < ROWS; i++) begin
      set_row(i, sample_t'($urandom), effect_e'(3'($urandom % 5)), volume_t'($urandom));
    end
  endtask

  // New bit goes out one hwclk after i2sclk drops
  task automatic drive_after_fall(input logic b);
    @(negedge i2sclk);
    @(posedge hwclk);
    #1 adc_serial_in = b;
  endtask

  task automatic drive_left_word(input sample_t s, input effect_e fx, input volume_t vol);
    sample_t bits;
    bits = s;
    @(negedge ws);  // Left word opens
    @(posedge hwclk);
    #1;
    effect_sel    = fx;  // Held for the whole word
    volume        = vol;
    adc_serial_in = bits[WORD_BITS-1];
    repeat (WORD_BITS - 1) begin
      bits = bits << 1;
      drive_after_fall(bits[WORD_BITS-1]);
    end
  endtask

  task automatic drive_right_word();
    sample_t bits;
    bits = sample_t'($urandom);  // Noise the DUT must drop
    repeat (WORD_BITS) begin
      drive_after_fall(bits[WORD_BITS-1]);
      bits = bits << 1;
    end
  endtask

  initial begin
    seed_val      = $urandom(SEED);
    rst           = 1'b1;
    adc_serial_in = 1'b0;
    effect_sel    = BYPASS;
    volume        = '0;
    fill_table();
    repeat (2) @(posedge hwclk);
    #1 rst = 1'b0;
    for (int r = 0; r < ROWS; r++) begin
      drive_left_word(row_sample[r], row_effect[r], row_volume[r]);
      drive_right_word();
    end
    wait (left_checked >= ROWS + 2);  // Row r reaches DAC left word r+2
    $display("Done: %0d checks passed, %0d checks failed, %0d assertion failures",
             pass_count, fail_count, i_dut.i_props.assert_fails);
    if (fail_count == 0 && i_dut.i_props.assert_fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
